//--- source/motor_pkg.sv
////////////////////
// Motor subsystem shared definitions
// Register map, field widths, tick rates and bus structs
////////////////////
`default_nettype none

package motor_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int addr_w     = 6;              // Register address
    localparam int data_w     = 8;              // Register data
    localparam int speed_w    = 5;              // Drive speed field
    localparam int mask_w     = 3;              // LED mask field
    localparam int level_w    = 4;              // LED brightness field
    localparam int num_motors = 4;              // Drive channels
    localparam int num_leds   = 4;              // Status LEDs incl. debug

    ////////////////////
    // Register map
    ////////////////////
    localparam logic [addr_w-1:0] addr_drive_enable = 6'h00;   // Per-motor enables
    localparam logic [addr_w-1:0] addr_drive_speed0 = 6'h02;   // Speeds 0..3 at 0x02..0x05
    localparam logic [addr_w-1:0] addr_led_mask     = 6'h06;   // Fault, pi, ps4
    localparam logic [addr_w-1:0] addr_led_level    = 6'h07;   // Shared brightness

    // Bit positions inside the LED mask
    localparam int led_fault = 0;
    localparam int led_pi    = 1;
    localparam int led_ps4   = 2;

    ////////////////////
    // Frame and tick rates
    ////////////////////
    localparam int frame_bits      = 16;        // SPI frame length
    localparam int drive_tick_log2 = 2;         // Drive tick every 4 clocks
    localparam int led_tick_log2   = 3;         // LED tick every 8 clocks

    // Field to duty scaling, as left shifts
    localparam int speed_shift = 2;             // Speed x 4
    localparam int level_shift = 4;             // Level x 16

    ////////////////////
    // Types
    ////////////////////
    typedef logic [data_w-1:0] duty_t;          // PWM high count out of 256

    // Register access strobes from the SPI side
    typedef struct packed {
        logic [addr_w-1:0] address;             // Target register
        logic              write_en;            // One-clock write pulse
        logic [data_w-1:0] wr_data;             // Write payload
        logic              read_en;             // One-clock read pulse
    } reg_bus_t;

    // Drive motor settings
    typedef struct packed {
        logic [num_motors-1:0]              enable;
        logic [num_motors-1:0][speed_w-1:0] speed;
    } drive_cfg_t;

    // Status LED settings
    typedef struct packed {
        logic [mask_w-1:0]  mask;
        logic [level_w-1:0] level;
    } led_cfg_t;

endpackage

`default_nettype wire

//--- source/spi_target.sv
////////////////////
// SPI mode-0 target
// Oversamples the pins and turns 16-bit frames into register strobes
////////////////////
`default_nettype none

module spi_target (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         spi_clock,
    input  logic                         cs_n,
    input  logic                         mosi,
    input  logic [motor_pkg::data_w-1:0] rd_data,
    output logic                         miso,
    output motor_pkg::reg_bus_t          bus
);
    import motor_pkg::*;

    localparam int cnt_w     = $clog2(frame_bits + 1);
    localparam int read_edge = frame_bits - data_w;     // Header length in bits

    logic [2:0]            sclk_sync;       // Two sync stages plus edge history
    logic [1:0]            cs_sync;
    logic [1:0]            mosi_sync;
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic [cnt_w-1:0]      bit_cnt;         // Rising edges seen this frame
    logic [frame_bits-1:0] rx_shift;
    logic [frame_bits-1:0] rx_next;
    logic                  rd_load;         // rd_data is valid this clock
    logic [data_w-1:0]     tx_shift;
    logic                  miso_q;

    ////////////////////
    // Pin synchronisers
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;                // Deselected out of reset
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign rx_next   = {rx_shift[frame_bits-2:0], mosi_sync[1]};   // MSB first

    always_ff @(posedge clock) begin
        if (sclk_rise) begin
            rx_shift <= rx_next;
        end
    end

    ////////////////////
    // Receive and strobes
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt <= '0;
            bus     <= '0;
        end else begin
            bus.write_en <= 1'b0;           // Strobes last one clock
            bus.read_en  <= 1'b0;
            if (cs_sync[1]) begin
                bit_cnt <= '0;              // Frame abort or idle
            end else if (sclk_rise && bit_cnt != cnt_w'(frame_bits)) begin
                bit_cnt <= bit_cnt + 1'b1;
                // Header complete, flag is clear so this is a read
                if (bit_cnt == cnt_w'(read_edge - 1) && !rx_next[read_edge-1]) begin
                    bus.address <= rx_next[addr_w-1:0];
                    bus.read_en <= 1'b1;
                end
                // Last bit of a write frame
                if (bit_cnt == cnt_w'(frame_bits - 1) && rx_next[frame_bits-1]) begin
                    bus.address  <= rx_next[data_w +: addr_w];     // Bits 13..8
                    bus.wr_data  <= rx_next[data_w-1:0];
                    bus.write_en <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Readback shifter
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_load  <= 1'b0;
            tx_shift <= '0;
            miso_q   <= 1'b0;
        end else begin
            rd_load <= bus.read_en;         // reg_file answers one clock later
            if (cs_sync[1]) begin
                tx_shift <= '0;
                miso_q   <= 1'b0;
            end else if (rd_load) begin
                tx_shift <= rd_data;
            end else if (sclk_fall) begin
                miso_q   <= tx_shift[data_w-1];                // Host samples on next rise
                tx_shift <= {tx_shift[data_w-2:0], 1'b0};
            end
        end
    end

    assign miso = miso_q & ~cs_n;           // Quiet while deselected

    // Readback load lands before the first data bit goes out
    assert property (@(posedge clock) disable iff (!reset_n)
        rd_load |-> !sclk_fall)
        else $error("falling spi_clock edge collided with the readback load");

endmodule

`default_nettype wire

//--- source/reg_file.sv
////////////////////
// Control register file
// Address decode, field storage and registered readback
////////////////////
`default_nettype none

module reg_file (
    input  logic                         clock,
    input  logic                         reset_n,
    input  motor_pkg::reg_bus_t          bus,
    output logic [motor_pkg::data_w-1:0] rd_data,
    output motor_pkg::drive_cfg_t        drive,
    output motor_pkg::led_cfg_t          leds
);
    import motor_pkg::*;

    localparam int sel_w = $clog2(num_motors);

    logic [addr_w-1:0] speed_off;           // Offset into the speed block
    logic              speed_hit;
    logic [sel_w-1:0]  speed_sel;
    logic              enable_hit;
    logic              mask_hit;
    logic              level_hit;
    logic [data_w-1:0] rd_next;

    ////////////////////
    // Address decode
    ////////////////////
    assign speed_off  = bus.address - addr_drive_speed0;   // Wraps high below the block
    assign speed_hit  = speed_off < addr_w'(num_motors);
    assign speed_sel  = speed_off[sel_w-1:0];
    assign enable_hit = bus.address == addr_drive_enable;
    assign mask_hit   = bus.address == addr_led_mask;
    assign level_hit  = bus.address == addr_led_level;

    ////////////////////
    // Field writes
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            drive <= '0;
            leds  <= '0;
        end else if (bus.write_en) begin
            // Upper bits of each field are dropped here
            if (enable_hit) begin
                drive.enable <= bus.wr_data[num_motors-1:0];
            end else if (speed_hit) begin
                drive.speed[speed_sel] <= bus.wr_data[speed_w-1:0];
            end else if (mask_hit) begin
                leds.mask <= bus.wr_data[mask_w-1:0];
            end else if (level_hit) begin
                leds.level <= bus.wr_data[level_w-1:0];
            end
        end
    end

    ////////////////////
    // Readback
    ////////////////////
    always_comb begin
        rd_next = '0;                       // Unmapped reads as zero
        if (enable_hit) begin
            rd_next = data_w'(drive.enable);
        end else if (speed_hit) begin
            rd_next = data_w'(drive.speed[speed_sel]);
        end else if (mask_hit) begin
            rd_next = data_w'(leds.mask);
        end else if (level_hit) begin
            rd_next = data_w'(leds.level);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= rd_next;             // Held until the next read
        end
    end

    // A write ends a frame, a read needs a fresh 8-bit header
    assert property (@(posedge clock) disable iff (!reset_n)
        bus.write_en |=> !bus.read_en)
        else $error("read strobe right after write strobe");

endmodule

`default_nettype wire

//--- source/tick_divider.sv
////////////////////
// PWM time base divider
// Drive and LED tick enables from one free-running counter
////////////////////
`default_nettype none

module tick_divider (
    input  logic clock,
    input  logic reset_n,
    output logic drive_tick,
    output logic led_tick
);
    import motor_pkg::*;

    logic [led_tick_log2-1:0] div_cnt;      // Wraps every LED tick period

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Registered so each tick is a clean one-clock pulse
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            drive_tick <= 1'b0;
            led_tick   <= 1'b0;
        end else begin
            drive_tick <= &div_cnt[drive_tick_log2-1:0];   // Low bits wrap
            led_tick   <= &div_cnt;                        // Whole counter wraps
        end
    end

endmodule

`default_nettype wire

//--- source/pwm_gen.sv
////////////////////
// 8-bit PWM generator
// Ratio taken at period wrap so each period is glitch free
////////////////////
`default_nettype none

module pwm_gen (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             tick,
    input  motor_pkg::duty_t ratio,
    output logic             pwm_signal
);
    import motor_pkg::*;

    duty_t period_cnt;                      // 256 ticks per period
    duty_t ratio_q;                         // Ratio for the running period
    logic  wrap;

    assign wrap = tick && (period_cnt == '1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
            ratio_q    <= '0;
        end else if (tick) begin
            period_cnt <= period_cnt + 1'b1;
            if (wrap) begin
                ratio_q <= ratio;           // New duty from next period
            end
        end
    end

    // High while the count is below the ratio
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pwm_signal <= 1'b0;
        end else begin
            pwm_signal <= period_cnt < ratio_q;
        end
    end

    // A high phase only starts at the top of a period
    assert property (@(posedge clock) disable iff (!reset_n)
        $rose(pwm_signal) |-> $past(period_cnt) == '0)
        else $error("pwm output rose away from the start of a period");

endmodule

`default_nettype wire

//--- source/fpga_subsystem.sv
////////////////////
// Robot FPGA subsystem, host side
// SPI registers driving four drive PWMs and the status LEDs
////////////////////
`default_nettype none

module fpga_subsystem (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             spi_clock,      // Mode 0
    input  logic                             cs_n,
    input  logic                             mosi,
    output logic                             miso,
    output logic [motor_pkg::num_motors-1:0] sd_pwm,         // Drive motor waves
    output logic                             status_fault,
    output logic                             status_pi,
    output logic                             status_ps4,
    output logic                             status_debug
);
    import motor_pkg::*;

    reg_bus_t                bus;           // SPI to register strobes
    logic [data_w-1:0]       rd_data;
    drive_cfg_t              drive;
    led_cfg_t                leds;
    logic                    drive_tick;
    logic                    led_tick;
    duty_t [num_motors-1:0]  drive_ratio;
    duty_t                   led_ratio;
    logic                    light_wave;    // Shared brightness wave
    logic [num_leds-1:0]     led_out;

    ////////////////////
    // Host interface
    ////////////////////
    spi_target u_spi (
        .clock     (clock),
        .reset_n   (reset_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .rd_data   (rd_data),
        .miso      (miso),
        .bus       (bus)
    );

    reg_file u_regs (
        .clock     (clock),
        .reset_n   (reset_n),
        .bus       (bus),
        .rd_data   (rd_data),
        .drive     (drive),
        .leds      (leds)
    );

    tick_divider u_ticks (
        .clock      (clock),
        .reset_n    (reset_n),
        .drive_tick (drive_tick),
        .led_tick   (led_tick)
    );

    ////////////////////
    // Duty ratios
    ////////////////////
    always_comb begin
        for (int i = 0; i < num_motors; i++) begin
            // Disabled motor idles low
            drive_ratio[i] = drive.enable[i] ? duty_t'(drive.speed[i]) << speed_shift : '0;
        end
        led_ratio = duty_t'(leds.level) << level_shift;
    end

    for (genvar i = 0; i < num_motors; i++) begin : g_drive
        pwm_gen u_pwm (
            .clock      (clock),
            .reset_n    (reset_n),
            .tick       (drive_tick),
            .ratio      (drive_ratio[i]),
            .pwm_signal (sd_pwm[i])
        );
    end

    pwm_gen u_lights (
        .clock      (clock),
        .reset_n    (reset_n),
        .tick       (led_tick),
        .ratio      (led_ratio),
        .pwm_signal (light_wave)
    );

    ////////////////////
    // Status LEDs
    ////////////////////
    assign led_out      = {1'b1, leds.mask} & {num_leds{light_wave}};   // Debug always lit
    assign status_fault = led_out[led_fault];
    assign status_pi    = led_out[led_pi];
    assign status_ps4   = led_out[led_ps4];
    assign status_debug = led_out[num_leds-1];

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
////////////////////
// Testbench clock and reset source
////////////////////
`default_nettype none

module tb_clock (
    output logic clock,
    output logic reset_n
);
    localparam int half_period  = 20;      // 40 unit period
    localparam int reset_cycles = 3;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    initial begin
        reset_n = 1'b0;                     // Held low from time zero
        repeat (reset_cycles) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_fpga_subsystem.sv
////////////////////
// Testbench for the FPGA subsystem
// Random SPI register traffic and PWM duty measurement against a model
////////////////////
`default_nettype none

module tb_fpga_subsystem;

    localparam int frame_clocks   = 150;                            // 16 bits x 8 plus framing
    localparam int num_frames     = 8 + 40 + 2 * 7 + 2;
    localparam int measure_clocks = 2048 + 2 * (3 * 1024 + 3 * 2048);
    localparam int timeout_cycles = num_frames * frame_clocks + measure_clocks + 2000;

    logic        clock;
    logic        reset_n;
    logic        spi_clock;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic [3:0]  sd_pwm;
    logic        status_fault;
    logic        status_pi;
    logic        status_ps4;
    logic        status_debug;
    logic [8:0]  observed;                  // Every DUT output in one vector
    logic [15:0] lfsr_state;
    logic [7:0]  model_regs [0:63];         // Expected register contents
    int          high_cnt [0:8];
    int          cycle_cnt;

    tb_clock u_clock (
        .clock   (clock),
        .reset_n (reset_n)
    );

    fpga_subsystem dut (
        .clock        (clock),
        .reset_n      (reset_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .sd_pwm       (sd_pwm),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    assign observed = {miso, status_debug, status_ps4, status_pi, status_fault, sd_pwm};

    ////////////////////
    // Random source and register model
    ////////////////////
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};   // x16+x14+x13+x11
    endfunction

    task automatic take_bits(input int nbits, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = next_lfsr(lfsr_state);     // One step per bit
            value      = {value[14:0], lfsr_state[0]};
        end
    endtask

    // Writable bits of each register, zero where unmapped
    function automatic logic [7:0] field_mask(input logic [5:0] addr);
        case (addr)
            6'h00:                      return 8'h0F;   // Drive enables
            6'h02, 6'h03, 6'h04, 6'h05: return 8'h1F;   // Drive speeds
            6'h06:                      return 8'h07;   // LED mask
            6'h07:                      return 8'h0F;   // LED level
            default:                    return 8'h00;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    ////////////////////
    // SPI host driver
    ////////////////////
    task automatic spi_bit(input logic bit_out, output logic bit_in);
        mosi <= bit_out;                    // Changes while spi_clock is low
        repeat (4) @(posedge clock);
        spi_clock <= 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        bit_in = miso;                      // Mid high phase, miso settled
        repeat (2) @(posedge clock);
        spi_clock <= 1'b0;
    endtask

    // Sends the top nbits of a frame, fewer than 16 aborts it
    task automatic spi_frame(input logic [15:0] frame, input int nbits, output logic [7:0] rx);
        logic b;
        rx = '0;
        cs_n <= 1'b0;
        repeat (4) @(posedge clock);
        for (int i = 15; i > 15 - nbits; i--) begin
            spi_bit(frame[i], b);
            if (i < 8) begin
                rx[i] = b;                  // Data byte comes back MSB first
            end
        end
        repeat (4) @(posedge clock);
        cs_n <= 1'b1;
        repeat (4) @(posedge clock);
    endtask

    task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
        logic [15:0] junk;
        logic [7:0]  rx;
        take_bits(1, junk);                 // Bit 14 is don't care
        spi_frame({1'b1, junk[0], addr, data}, 16, rx);
        model_regs[addr] = data & field_mask(addr);
    endtask

    task automatic read_check(input logic [5:0] addr);
        logic [15:0] junk;
        logic [7:0]  rx;
        take_bits(9, junk);                 // Bit 14 and filler data
        spi_frame({1'b0, junk[8], addr, junk[7:0]}, 16, rx);
        check_value(rx, model_regs[addr], $sformatf("read of address 0x%02h", addr));
    endtask

    // High clocks per output over a window, sampled away from the edges
    task automatic count_high(input int window);
        for (int j = 0; j < 9; j++) begin
            high_cnt[j] = 0;
        end
        repeat (window) begin
            @(negedge clock);
            for (int j = 0; j < 9; j++) begin
                high_cnt[j] += observed[j];
            end
        end
    endtask

    ////////////////////
    // Duty tests
    ////////////////////
    task automatic drive_duty_test();
        logic [15:0] value;
        int          expected;
        take_bits(8, value);
        write_reg(6'h00, value[7:0]);
        for (int i = 0; i < 4; i++) begin
            take_bits(8, value);            // Upper bits land outside the field
            write_reg(6'h02 + i, value[7:0]);
        end
        repeat (2048) @(posedge clock);     // Two drive periods
        count_high(1024);
        for (int i = 0; i < 4; i++) begin
            expected = model_regs[0][i] ? int'(model_regs[2 + i]) * 4 * 4 : 0;
            check_value(high_cnt[i], expected, $sformatf("sd_pwm[%0d] high clocks", i));
        end
    endtask

    task automatic led_duty_test();
        logic [15:0] value;
        int          lit;
        take_bits(8, value);
        write_reg(6'h07, value[7:0]);
        take_bits(8, value);
        write_reg(6'h06, value[7:0]);
        repeat (4096) @(posedge clock);     // Two LED periods
        count_high(2048);
        lit = int'(model_regs[7]) * 16 * 8;
        check_value(high_cnt[7], lit, "status_debug high clocks");
        for (int k = 0; k < 3; k++) begin
            check_value(high_cnt[4 + k], model_regs[6][k] ? lit : 0,
                $sformatf("status LED %0d high clocks", k));
        end
    endtask

    ////////////////////
    // Watchdog
    ////////////////////
    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: run passed %0d clock cycles without finishing", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [15:0] value;
        logic [7:0]  rx;
        logic [5:0]  addr;
        spi_clock   <= 1'b0;
        cs_n        <= 1'b1;                // Deselected
        mosi        <= 1'b0;
        cycle_cnt   = 0;
        lfsr_state  = 16'd26;
        for (int a = 0; a < 64; a++) begin
            model_regs[a] = '0;
        end
        @(posedge reset_n);
        repeat (2) @(posedge clock);

        // Idle outputs and reset values
        count_high(2048);
        for (int j = 0; j < 9; j++) begin
            check_value(high_cnt[j], 0, $sformatf("output %0d high after reset", j));
        end
        for (int a = 0; a < 8; a++) begin
            read_check(a);
        end

        // Random write then readback
        repeat (20) begin
            take_bits(4, value);
            addr = {2'b00, value[3:0]};     // Range 0x00 to 0x0F
            take_bits(8, value);
            write_reg(addr, value[7:0]);
            read_check(addr);
        end

        repeat (2) begin
            drive_duty_test();
            led_duty_test();
        end

        // Aborted write leaves the register alone
        take_bits(3, value);
        addr = {3'b000, value[2:0]};
        if (field_mask(addr) == 8'h00) begin
            addr = 6'h00;                   // Unmapped slot has nothing to corrupt
        end
        spi_frame({1'b1, 1'b0, addr, ~model_regs[addr]}, 10, rx);
        read_check(addr);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/motor_pkg.sv
source/spi_target.sv
source/reg_file.sv
source/tick_divider.sv
source/pwm_gen.sv
source/fpga_subsystem.sv
sim/tb_clock.sv
sim/tb_fpga_subsystem.sv
